// ==== schedTypes.sv ====
package schedTypes;

    // Core sizes
    localparam int PHYS_REG_NUM   = 32;
    localparam int PREG_WIDTH     = 5;
    localparam int DISPATCH_WIDTH = 2;
    localparam int SRC_OP_NUM     = 2;
    localparam int WAKEUP_WIDTH   = 2;

    // Ready table port counts
    localparam int READY_WRITE_NUM = WAKEUP_WIDTH + DISPATCH_WIDTH;
    localparam int READY_READ_NUM  = DISPATCH_WIDTH * SRC_OP_NUM;

    typedef logic [PREG_WIDTH-1:0] PRegNum;

    // One micro-op as seen by dispatch
    typedef struct packed {
        logic                    valid;
        logic                    dstValid;
        PRegNum                  dst;
        logic [SRC_OP_NUM-1:0]   srcValid;
        PRegNum [SRC_OP_NUM-1:0] src;
    } DispatchOp;

    typedef DispatchOp [DISPATCH_WIDTH-1:0] DispatchGroup;

    // Micro-op annotated with source readiness for the issue queue
    typedef struct packed {
        DispatchOp             op;
        logic [SRC_OP_NUM-1:0] srcReady;
    } IssueOp;

    typedef IssueOp [DISPATCH_WIDTH-1:0] IssueGroup;

    // Result broadcast from the execution side
    typedef struct packed {
        logic   valid;
        PRegNum dst;
    } WakeupLane;

    typedef WakeupLane [WAKEUP_WIDTH-1:0] WakeupBus;

endpackage

// ==== multiPortRam.sv ====
`timescale 1ns/10ps

module multiPortRam #(
    parameter int ENTRY_NUM = 32,
    parameter int READ_NUM  = 4,
    parameter int WRITE_NUM = 4
) (
    input  logic                                         clk,
    input  logic [WRITE_NUM-1:0]                         we,
    input  logic [WRITE_NUM-1:0][$clog2(ENTRY_NUM)-1:0]  wa,
    input  logic [WRITE_NUM-1:0]                         wv,
    input  logic [READ_NUM-1:0][$clog2(ENTRY_NUM)-1:0]   ra,
    output logic [READ_NUM-1:0]                          rv
);

    // One bit per entry, held in flops
    logic mem [ENTRY_NUM];

    // Ports are visited in order, so the highest enabled port lands last
    always_ff @(posedge clk) begin
        for (int i = 0; i < WRITE_NUM; i++) begin
            if (we[i]) begin
                mem[wa[i]] <= wv[i];
            end
        end
    end

    // Reads are asynchronous and see the contents before this edge
    always_comb begin
        for (int i = 0; i < READ_NUM; i++) begin
            rv[i] = mem[ra[i]];
        end
    end

endmodule

// ==== readyInitSequencer.sv ====
`timescale 1ns/10ps

module readyInitSequencer (
    input  logic               clk,
    input  logic               rst,
    output schedTypes::PRegNum initIndex,
    output logic               initBusy
);

    import schedTypes::*;

    logic sweepDone;

    // Reset clears the done flag, which arms a fresh sweep from entry 0
    always_ff @(posedge clk) begin
        if (rst) begin
            initIndex <= '0;
            sweepDone <= 1'b0;
        end else if (!sweepDone) begin
            initIndex <= initIndex + 1'b1;
            if (initIndex == PRegNum'(PHYS_REG_NUM - 1)) begin
                sweepDone <= 1'b1;
            end
        end
    end

    // Busy from the first cycle after reset until the last entry is written
    assign initBusy = !sweepDone && !rst;

endmodule

// ==== readyBitTable.sv ====
`timescale 1ns/10ps

module readyBitTable (
    input  logic                     clk,
    input  schedTypes::PRegNum       initIndex,
    input  logic                     initBusy,
    input  schedTypes::WakeupBus     wakeup,
    input  logic                     dispatchFire,
    input  schedTypes::DispatchGroup group,
    output logic [schedTypes::DISPATCH_WIDTH-1:0][schedTypes::SRC_OP_NUM-1:0] lookupReady
);

    import schedTypes::*;

    logic   [READY_WRITE_NUM-1:0] readyWe;
    PRegNum [READY_WRITE_NUM-1:0] readyWa;
    logic   [READY_WRITE_NUM-1:0] readyWv;
    PRegNum [READY_READ_NUM-1:0]  readyRa;
    logic   [READY_READ_NUM-1:0]  readyRv;

    multiPortRam #(
        .ENTRY_NUM (PHYS_REG_NUM),
        .READ_NUM  (READY_READ_NUM),
        .WRITE_NUM (READY_WRITE_NUM)
    ) readyRam (
        .clk (clk),
        .we  (readyWe),
        .wa  (readyWa),
        .wv  (readyWv),
        .ra  (readyRa),
        .rv  (readyRv)
    );

    // Write ports. Wakeups set on the low ports, dispatch clears on the
    // high ports so that a clear overrides a set of the same register
    always_comb begin
        for (int i = 0; i < WAKEUP_WIDTH; i++) begin
            readyWa[i] = wakeup[i].dst;
            readyWv[i] = 1'b1;
            readyWe[i] = wakeup[i].valid && !initBusy;
        end

        for (int i = 0; i < DISPATCH_WIDTH; i++) begin
            readyWa[WAKEUP_WIDTH + i] = group[i].dst;
            readyWv[WAKEUP_WIDTH + i] = 1'b0;
            readyWe[WAKEUP_WIDTH + i] = dispatchFire && group[i].valid &&
                                        group[i].dstValid && !initBusy;
        end

        // Sweep borrows port 0 while everything else is held off
        if (initBusy) begin
            readyWa[0] = initIndex;
            readyWv[0] = 1'b1;
            readyWe[0] = 1'b1;
        end
    end

    // Each lane and source has its own read port
    always_comb begin
        for (int i = 0; i < DISPATCH_WIDTH; i++) begin
            for (int j = 0; j < SRC_OP_NUM; j++) begin
                readyRa[i*SRC_OP_NUM + j] = group[i].src[j];
            end
        end
    end

    // Source lookup with same-cycle bypasses
    always_comb begin
        for (int i = 0; i < DISPATCH_WIDTH; i++) begin
            for (int j = 0; j < SRC_OP_NUM; j++) begin
                if (!group[i].srcValid[j]) begin
                    lookupReady[i][j] = 1'b1;
                end else begin
                    lookupReady[i][j] = readyRv[i*SRC_OP_NUM + j];

                    // A result arriving now is already usable
                    for (int k = 0; k < WAKEUP_WIDTH; k++) begin
                        if (wakeup[k].valid && wakeup[k].dst == group[i].src[j]) begin
                            lookupReady[i][j] = 1'b1;
                        end
                    end

                    // An older lane in the group is about to overwrite this register
                    for (int k = 0; k < i; k++) begin
                        if (group[k].valid && group[k].dstValid &&
                            group[k].dst == group[i].src[j]) begin
                            lookupReady[i][j] = 1'b0;
                        end
                    end
                end
            end
        end
    end

endmodule

// ==== dispatchStage.sv ====
`timescale 1ns/10ps

module dispatchStage (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     initBusy,
    input  schedTypes::DispatchGroup inGroup,
    input  logic                     inValid,
    output logic                     inReady,
    input  schedTypes::WakeupBus     wakeup,
    input  logic [schedTypes::DISPATCH_WIDTH-1:0][schedTypes::SRC_OP_NUM-1:0] lookupReady,
    output logic                     dispatchFire,
    output schedTypes::IssueGroup    outGroup,
    output logic                     outValid,
    input  logic                     outReady
);

    import schedTypes::*;

    IssueGroup heldGroup;

    // Single register stage, full throughput once the table is swept
    assign inReady      = !rst && !initBusy && (!outValid || outReady);
    assign dispatchFire = inValid && inReady;

    // Held group picks up wakeups that arrive while it waits downstream
    always_comb begin
        heldGroup = outGroup;
        for (int i = 0; i < DISPATCH_WIDTH; i++) begin
            for (int j = 0; j < SRC_OP_NUM; j++) begin
                for (int k = 0; k < WAKEUP_WIDTH; k++) begin
                    if (wakeup[k].valid && wakeup[k].dst == outGroup[i].op.src[j]) begin
                        heldGroup[i].srcReady[j] = 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            outValid <= 1'b0;
        end else if (dispatchFire) begin
            outValid <= 1'b1;
        end else if (outReady) begin
            outValid <= 1'b0;
        end
    end

    // Op fields stay fixed until the next acceptance
    always_ff @(posedge clk) begin
        if (dispatchFire) begin
            for (int i = 0; i < DISPATCH_WIDTH; i++) begin
                outGroup[i].op       <= inGroup[i];
                outGroup[i].srcReady <= lookupReady[i];
            end
        end else begin
            outGroup <= heldGroup;
        end
    end

endmodule

// ==== dispatchReadyTop.sv ====
`timescale 1ns/10ps

module dispatchReadyTop (
    input  logic                     clk,
    input  logic                     rst,
    input  schedTypes::DispatchGroup inGroup,
    input  logic                     inValid,
    output logic                     inReady,
    input  schedTypes::WakeupBus     wakeup,
    output schedTypes::IssueGroup    outGroup,
    output logic                     outValid,
    input  logic                     outReady
);

    import schedTypes::*;

    PRegNum initIndex;
    logic   initBusy;
    logic   dispatchFire;
    logic   [DISPATCH_WIDTH-1:0][SRC_OP_NUM-1:0] lookupReady;

    readyInitSequencer initSeq (
        .clk       (clk),
        .rst       (rst),
        .initIndex (initIndex),
        .initBusy  (initBusy)
    );

    readyBitTable readyTable (
        .clk          (clk),
        .initIndex    (initIndex),
        .initBusy     (initBusy),
        .wakeup       (wakeup),
        .dispatchFire (dispatchFire),
        .group        (inGroup),
        .lookupReady  (lookupReady)
    );

    dispatchStage stage (
        .clk          (clk),
        .rst          (rst),
        .initBusy     (initBusy),
        .inGroup      (inGroup),
        .inValid      (inValid),
        .inReady      (inReady),
        .wakeup       (wakeup),
        .lookupReady  (lookupReady),
        .dispatchFire (dispatchFire),
        .outGroup     (outGroup),
        .outValid     (outValid),
        .outReady     (outReady)
    );

endmodule

// ==== dispatchReadyTb.sv ====
`timescale 1ns/10ps

module dispatchReadyTb;

    import schedTypes::*;

    localparam int TABLE_ROWS  = 11;
    localparam int RANDOM_NUM  = 300;
    localparam int WATCHDOG_NS = (4 + 32 + TABLE_ROWS + RANDOM_NUM) * 4 * 40;

    typedef struct packed {
        DispatchGroup              grp;
        logic                      vld;
        WakeupBus                  wk;
        logic                      rdy;
        logic [READY_READ_NUM-1:0] expReady;
    } StimRow;

    logic         clk = 1'b0;
    logic         rst;
    DispatchGroup inGroup;
    logic         inValid;
    logic         inReady;
    WakeupBus     wakeup;
    IssueGroup    outGroup;
    logic         outValid;
    logic         outReady;

    // Reference state
    logic [PHYS_REG_NUM-1:0]   modelReady;
    IssueGroup                 modelOut;
    logic                      modelOutValid;
    logic                      lastFire;
    logic                      pendingCheck;
    logic [READY_READ_NUM-1:0] pendingExp;
    int                        acceptCount;
    int                        leaveCount;
    logic [31:0]               lcgState = 32'd84659;
    StimRow                    stimRows[$];

    dispatchReadyTop uut (
        .clk      (clk),
        .rst      (rst),
        .inGroup  (inGroup),
        .inValid  (inValid),
        .inReady  (inReady),
        .wakeup   (wakeup),
        .outGroup (outGroup),
        .outValid (outValid),
        .outReady (outReady)
    );

    always #20 clk = ~clk;

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the testbench did not finish in %0d ns", WATCHDOG_NS);
        $display("Regression failed");
        $fatal(1);
    end

    task automatic checkValue(input string name, input logic [63:0] observed,
                              input logic [63:0] expected);
        if (observed !== expected) begin
            $display("CHECK FAILED at %0t: %s observed %h expected %h",
                     $time, name, observed, expected);
            $display("Regression failed");
            $fatal(1);
        end
    endtask

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return {16'd0, lcgState[31:16]};
    endfunction

    // Negative register numbers mean the field is not used
    function automatic DispatchOp mkOp(input int dst, input int s0, input int s1);
        DispatchOp op;
        op.valid       = 1'b1;
        op.dstValid    = (dst >= 0);
        op.dst         = (dst >= 0) ? PRegNum'(dst) : '0;
        op.srcValid[0] = (s0 >= 0);
        op.src[0]      = (s0 >= 0) ? PRegNum'(s0) : '0;
        op.srcValid[1] = (s1 >= 0);
        op.src[1]      = (s1 >= 0) ? PRegNum'(s1) : '0;
        return op;
    endfunction

    function automatic WakeupBus mkWake(input int r0, input int r1);
        WakeupBus wk;
        wk[0].valid = (r0 >= 0);
        wk[0].dst   = (r0 >= 0) ? PRegNum'(r0) : '0;
        wk[1].valid = (r1 >= 0);
        wk[1].dst   = (r1 >= 0) ? PRegNum'(r1) : '0;
        return wk;
    endfunction

    // Small register range so that random traffic collides often
    function automatic DispatchOp randomOp();
        DispatchOp op;
        op.valid    = (nextRand() % 8) != 0;
        op.dstValid = (nextRand() % 4) != 0;
        op.dst      = PRegNum'(nextRand() % 12);
        for (int j = 0; j < SRC_OP_NUM; j++) begin
            op.srcValid[j] = (nextRand() % 4) != 0;
            op.src[j]      = PRegNum'(nextRand() % 12);
        end
        return op;
    endfunction

    function automatic logic [READY_READ_NUM-1:0] srcReadyBits(input IssueGroup g);
        logic [READY_READ_NUM-1:0] bits;
        for (int i = 0; i < DISPATCH_WIDTH; i++) begin
            for (int j = 0; j < SRC_OP_NUM; j++) begin
                bits[i*SRC_OP_NUM + j] = g[i].srcReady[j];
            end
        end
        return bits;
    endfunction

    // Ready if unused, set in the table or woken now, unless an older lane writes it
    function automatic logic [READY_READ_NUM-1:0] lookupModel(input DispatchGroup grp,
                                                             input WakeupBus wk);
        logic [READY_READ_NUM-1:0] res;
        logic                      woken;
        logic                      claimed;
        for (int i = 0; i < DISPATCH_WIDTH; i++) begin
            for (int j = 0; j < SRC_OP_NUM; j++) begin
                woken   = 1'b0;
                claimed = 1'b0;
                for (int k = 0; k < WAKEUP_WIDTH; k++) begin
                    woken = woken || (wk[k].valid && wk[k].dst == grp[i].src[j]);
                end
                for (int k = 0; k < i; k++) begin
                    claimed = claimed || (grp[k].valid && grp[k].dstValid &&
                                          grp[k].dst == grp[i].src[j]);
                end
                res[i*SRC_OP_NUM + j] = !grp[i].srcValid[j] ||
                    ((modelReady[grp[i].src[j]] || woken) && !claimed);
            end
        end
        return res;
    endfunction

    task automatic addRow(input DispatchOp op0, input DispatchOp op1, input WakeupBus wk,
                          input logic vld, input logic rdy,
                          input logic [READY_READ_NUM-1:0] expReady);
        StimRow row;
        row.grp[0]   = op0;
        row.grp[1]   = op1;
        row.wk       = wk;
        row.vld      = vld;
        row.rdy      = rdy;
        row.expReady = expReady;
        stimRows.push_back(row);
    endtask

    // One clock: drive, check at the falling edge, then advance the model
    task automatic stepCycle(input DispatchGroup grp, input logic vld, input WakeupBus wk,
                             input logic rdy);
        logic                      fire;
        logic [READY_READ_NUM-1:0] look;
        @(posedge clk);
        inGroup  <= grp;
        inValid  <= vld;
        wakeup   <= wk;
        outReady <= rdy;
        @(negedge clk);
        if (pendingCheck) begin
            checkValue("outGroup.srcReady", 64'(srcReadyBits(outGroup)), 64'(pendingExp));
            pendingCheck = 1'b0;
        end
        checkValue("outValid", 64'(outValid), 64'(modelOutValid));
        if (modelOutValid) begin
            checkValue("outGroup", 64'(outGroup), 64'(modelOut));
        end
        checkValue("inReady", 64'(inReady), 64'(!modelOutValid || rdy));
        fire = vld && (!modelOutValid || rdy);
        // Handshakes as the DUT shows them
        if (outValid && rdy) begin
            leaveCount++;
        end
        if (vld && inReady) begin
            acceptCount++;
        end
        look = lookupModel(grp, wk);
        for (int i = 0; i < DISPATCH_WIDTH; i++) begin
            for (int j = 0; j < SRC_OP_NUM; j++) begin
                if (fire) begin
                    modelOut[i].op          = grp[i];
                    modelOut[i].srcReady[j] = look[i*SRC_OP_NUM + j];
                end else begin
                    for (int k = 0; k < WAKEUP_WIDTH; k++) begin
                        if (wk[k].valid && wk[k].dst == modelOut[i].op.src[j]) begin
                            modelOut[i].srcReady[j] = 1'b1;
                        end
                    end
                end
            end
        end
        // Wakeup sets first so that a dispatch clear of the same register wins
        for (int k = 0; k < WAKEUP_WIDTH; k++) begin
            if (wk[k].valid) begin
                modelReady[wk[k].dst] = 1'b1;
            end
        end
        for (int i = 0; i < DISPATCH_WIDTH; i++) begin
            if (fire && grp[i].valid && grp[i].dstValid) begin
                modelReady[grp[i].dst] = 1'b0;
            end
        end
        modelOutValid = fire ? 1'b1 : (rdy ? 1'b0 : modelOutValid);
        lastFire      = fire;
    endtask

    initial begin
        int           busyCycles;
        DispatchGroup grp;
        WakeupBus     wk;
        logic         vld;
        logic         rdy;
        rst           = 1'b1;
        inGroup       = '0;
        inValid       = 1'b0;
        wakeup        = '0;
        outReady      = 1'b0;
        modelReady    = '1;
        modelOut      = '0;
        modelOutValid = 1'b0;
        pendingCheck  = 1'b0;
        pendingExp    = '0;
        acceptCount   = 0;
        leaveCount    = 0;

        @(posedge clk);
        @(negedge clk);
        checkValue("inReady in reset", 64'(inReady), 64'(0));
        checkValue("outValid in reset", 64'(outValid), 64'(0));
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        // Sweep length seen from the input side
        busyCycles = 0;
        @(negedge clk);
        while (!inReady && busyCycles < 40) begin
            busyCycles++;
            @(negedge clk);
        end
        checkValue("inReady low cycles after reset", 64'(busyCycles), 64'(32));

        addRow(mkOp(1, 2, 3), mkOp(4, 5, 6), mkWake(-1, -1), 1'b1, 1'b1, 4'b1111);
        addRow(mkOp(7, 1, 2), mkOp(8, 4, -1), mkWake(-1, -1), 1'b1, 1'b1, 4'b1010);
        addRow(mkOp(9, 1, 4), mkOp(-1, 7, 9), mkWake(1, -1), 1'b1, 1'b1, 4'b0001);
        addRow(mkOp(-1, -1, -1), mkOp(-1, -1, -1), mkWake(4, 7), 1'b0, 1'b1, 4'b0000);
        addRow(mkOp(10, 4, 9), mkOp(11, 1, -1), mkWake(-1, -1), 1'b1, 1'b1, 4'b1101);
        // Held downstream, so these two rows are refused
        addRow(mkOp(12, 10, 11), mkOp(13, 2, 3), mkWake(-1, -1), 1'b1, 1'b0, 4'b0000);
        addRow(mkOp(12, 10, 11), mkOp(13, 2, 3), mkWake(9, -1), 1'b1, 1'b0, 4'b0000);
        addRow(mkOp(14, 12, 13), mkOp(15, 10, 3), mkWake(-1, -1), 1'b1, 1'b1, 4'b1011);
        // Wakeup and allocation of register 16 in the same cycle
        addRow(mkOp(16, 17, -1), mkOp(-1, -1, -1), mkWake(16, -1), 1'b1, 1'b1, 4'b1111);
        addRow(mkOp(-1, 16, 14), mkOp(-1, -1, 15), mkWake(-1, -1), 1'b1, 1'b1, 4'b0100);
        addRow(mkOp(-1, -1, -1), mkOp(-1, -1, -1), mkWake(-1, -1), 1'b0, 1'b1, 4'b0000);

        foreach (stimRows[r]) begin
            stepCycle(stimRows[r].grp, stimRows[r].vld, stimRows[r].wk, stimRows[r].rdy);
            if (lastFire) begin
                pendingCheck = 1'b1;
                pendingExp   = stimRows[r].expReady;
            end
        end

        for (int n = 0; n < RANDOM_NUM; n++) begin
            grp[0] = randomOp();
            grp[1] = randomOp();
            for (int k = 0; k < WAKEUP_WIDTH; k++) begin
                wk[k].valid = (nextRand() % 2) != 0;
                wk[k].dst   = PRegNum'(nextRand() % 12);
            end
            vld = (nextRand() % 4) != 0;
            rdy = (nextRand() % 4) != 0;
            stepCycle(grp, vld, wk, rdy);
        end

        // Drain the output register before counting
        grp = '0;
        repeat (2) stepCycle(grp, 1'b0, '0, 1'b1);
        checkValue("outValid after drain", 64'(outValid), 64'(0));
        checkValue("groups delivered vs accepted", 64'(leaveCount), 64'(acceptCount));

        $display("Regression passed");
        $finish;
    end

endmodule

// ==== compile.f ====
schedTypes.sv
multiPortRam.sv
readyInitSequencer.sv
readyBitTable.sv
dispatchStage.sv
dispatchReadyTop.sv
dispatchReadyTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the dispatch readiness testbench with Verilator and runs it

set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f compile.f --top-module dispatchReadyTb -o simDispatchReady
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

simOutput=$(./obj_dir/simDispatchReady 2>&1)
simStatus=$?
echo "$simOutput"

if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

# The testbench prints the pass line only when every check held
if echo "$simOutput" | grep -qx "Regression passed"; then
    exit 0
fi
echo "Pass line not found in simulation output"
exit 1
